// File: src/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

//////////////////////////////////////////////////
// array and buffer geometry
//////////////////////////////////////////////////

`define CONV_ROW_PIXELS 16   // pixels per buffered row
`define CONV_ROWS       3    // buffered rows, same as kernel height
`define CONV_K          3    // kernel size
`define CONV_TILE_COLS  4    // output pixels per tile
`define CONV_CHANNELS   2    // output channels

//////////////////////////////////////////////////
// word widths
//////////////////////////////////////////////////

`define CONV_PIXEL_W    8    // unsigned pixel
`define CONV_WEIGHT_W   8    // signed weight
`define CONV_ACC_W      24   // 16b product plus 8b headroom
`define CONV_IDX_W      5    // column index

`endif

// File: src/conv_pkg.sv
`include "conv_consts.svh"

package conv_pkg;

    //////////////////////////////////////////////////
    // data words
    //////////////////////////////////////////////////

    typedef logic [`CONV_PIXEL_W-1:0] pixel_t;
    typedef logic signed [`CONV_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    typedef pixel_t [`CONV_ROW_PIXELS-1:0] row_pixels_t;   // one buffered row
    typedef pixel_t [`CONV_TILE_COLS-1:0] pix_window_t;    // pixels for one tap
    typedef weight_t [`CONV_CHANNELS-1:0] tap_weights_t;   // one weight per channel

    //////////////////////////////////////////////////
    // tap descriptor and finished tile
    //////////////////////////////////////////////////

    // one kernel position of one tile, issued once per cycle
    typedef struct packed {
        logic [1:0]             ky;
        logic [1:0]             kx;
        logic [`CONV_IDX_W-1:0] tile_base;   // first output column
        logic                   first;       // tap 0 of the tile
        logic                   last;        // tap 8 of the tile
    } tap_t;

    typedef struct packed {
        acc_t [`CONV_CHANNELS-1:0][`CONV_TILE_COLS-1:0] acc;   // [channel][column]
        logic [`CONV_IDX_W-1:0]                        tile_base;
    } out_tile_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN     // waiting for the last tile to leave the array
    } seq_state_t;

endpackage

// File: src/conv_sequencer.sv
`timescale 1ns/100ps
`include "conv_consts.svh"

module conv_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [`CONV_IDX_W-1:0] ix,
    output logic                   busy,
    output logic                   done,
    output logic                   tap_valid,
    output conv_pkg::tap_t         tap
);
    import conv_pkg::*;

    localparam int DRAIN_CYCLES = 4;   // last tap to out_valid
    localparam logic [1:0] K_LAST = 2'(`CONV_K - 1);
    localparam logic [1:0] DRAIN_LAST = 2'(DRAIN_CYCLES - 1);
    localparam logic [`CONV_IDX_W-1:0] EDGE_COLS = `CONV_IDX_W'(`CONV_K - 1);
    localparam logic [`CONV_IDX_W:0] TILE_STEP = (`CONV_IDX_W + 1)'(`CONV_TILE_COLS);

    seq_state_t             state;
    logic [1:0]             ky;
    logic [1:0]             kx;
    logic [`CONV_IDX_W-1:0] tile_base;
    logic [`CONV_IDX_W-1:0] ox;          // output row width for this run
    logic [1:0]             drain_cnt;
    logic [`CONV_IDX_W:0]   next_base;
    logic                   last_tap;
    logic                   last_tile;

    assign next_base = {1'b0, tile_base} + TILE_STEP;
    assign last_tile = next_base >= {1'b0, ox};   // this tile covers the row end
    assign last_tap  = (ky == K_LAST) && (kx == K_LAST);

    //////////////////////////////////////////////////
    // FSM and tap counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            ky        <= '0;
            kx        <= '0;
            tile_base <= '0;
            ox        <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= RUN;
                        ky        <= '0;
                        kx        <= '0;
                        tile_base <= '0;
                        ox        <= ix - EDGE_COLS;   // valid outputs only
                    end
                end
                RUN: begin
                    if (kx == K_LAST) begin
                        kx <= '0;
                        if (ky == K_LAST) begin
                            ky <= '0;
                            if (last_tile) begin
                                state     <= DRAIN;
                                drain_cnt <= '0;
                            end else begin
                                tile_base <= next_base[`CONV_IDX_W-1:0];
                            end
                        end else begin
                            ky <= ky + 2'd1;
                        end
                    end else begin
                        kx <= kx + 2'd1;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == DRAIN_LAST) begin
                        state <= IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy      = (state != IDLE);
    assign tap_valid = (state == RUN);
    assign done      = (state == DRAIN) && (drain_cnt == DRAIN_LAST);   // lines up with final out_valid

    always_comb begin
        tap.ky        = ky;
        tap.kx        = kx;
        tap.tile_base = tile_base;
        tap.first     = (ky == 2'd0) && (kx == 2'd0);
        tap.last      = last_tap;
    end

endmodule

// File: src/line_buffer.sv
`timescale 1ns/100ps
`include "conv_consts.svh"

module line_buffer (
    input  logic                   clk,
    input  logic                   pix_wr,
    input  logic [1:0]             pix_wr_row,
    input  logic [`CONV_IDX_W-1:0] pix_wr_col,
    input  conv_pkg::pixel_t       pix_wr_data,
    input  logic [1:0]             rd_row,
    output conv_pkg::row_pixels_t  row_out
);
    import conv_pkg::*;

    localparam int COL_W = $clog2(`CONV_ROW_PIXELS);
    localparam logic [1:0] NUM_ROWS = 2'(`CONV_ROWS);
    localparam logic [`CONV_IDX_W-1:0] NUM_COLS = `CONV_IDX_W'(`CONV_ROW_PIXELS);

    row_pixels_t rows [`CONV_ROWS];   // one register row per kernel row
    logic        wr_ok;

    // writes outside the buffer are dropped
    assign wr_ok = pix_wr && (pix_wr_row < NUM_ROWS) && (pix_wr_col < NUM_COLS);

    //////////////////////////////////////////////////
    // single pixel write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            rows[pix_wr_row][pix_wr_col[COL_W-1:0]] <= pix_wr_data;
        end
    end

    //////////////////////////////////////////////////
    // whole row read, one cycle latency
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_row < NUM_ROWS) begin
            row_out <= rows[rd_row];
        end else begin
            row_out <= '0;   // no such row
        end
    end

endmodule

// File: src/window_shifter.sv
`timescale 1ns/100ps
`include "conv_consts.svh"

module window_shifter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tap_valid,
    input  conv_pkg::tap_t        tap,
    input  conv_pkg::row_pixels_t row_in,
    output logic                  win_valid,
    output conv_pkg::tap_t        win_tap,
    output conv_pkg::pix_window_t window,
    output conv_pkg::tap_t        mid_tap
);
    import conv_pkg::*;

    localparam int COL_W = $clog2(`CONV_ROW_PIXELS);
    localparam int SEL_W = `CONV_IDX_W + 1;
    localparam logic [SEL_W-1:0] NUM_COLS = SEL_W'(`CONV_ROW_PIXELS);

    logic             mid_valid;   // tap lines up with row_in here
    logic [SEL_W-1:0] win_start;
    logic [SEL_W-1:0] col;
    pix_window_t      sel;

    // four pixels from tile_base + kx, zero beyond the buffer
    always_comb begin
        win_start = {1'b0, mid_tap.tile_base} + SEL_W'(mid_tap.kx);
        col       = '0;
        for (int c = 0; c < `CONV_TILE_COLS; c++) begin
            col    = win_start + SEL_W'(c);
            sel[c] = (col < NUM_COLS) ? row_in[col[COL_W-1:0]] : '0;
        end
    end

    //////////////////////////////////////////////////
    // two pipeline stages
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mid_valid <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            mid_valid <= tap_valid;
            win_valid <= mid_valid;
        end
    end

    always_ff @(posedge clk) begin
        mid_tap <= tap;       // stage 1, also feeds the weight lookup
        win_tap <= mid_tap;   // stage 2
        window  <= sel;
    end

endmodule

// File: src/weight_store.sv
`timescale 1ns/100ps
`include "conv_consts.svh"

module weight_store (
    input  logic                                 clk,
    input  logic                                 w_wr,
    input  logic [$clog2(`CONV_CHANNELS)-1:0]    w_wr_ch,
    input  logic [1:0]                           w_wr_ky,
    input  logic [1:0]                           w_wr_kx,
    input  conv_pkg::weight_t                    w_wr_data,
    input  conv_pkg::tap_t                       rd_tap,
    output conv_pkg::tap_weights_t               weights
);
    import conv_pkg::*;

    localparam int TAPS = `CONV_K * `CONV_K;
    localparam int TAP_W = $clog2(TAPS);
    localparam logic [1:0] K_SIZE = 2'(`CONV_K);

    weight_t          mem [`CONV_CHANNELS][TAPS];   // [channel][ky*3+kx]
    logic [TAP_W-1:0] wr_idx;
    logic [TAP_W-1:0] rd_idx;
    logic             wr_ok;

    assign wr_idx = TAP_W'(w_wr_ky) * TAP_W'(`CONV_K) + TAP_W'(w_wr_kx);
    assign rd_idx = TAP_W'(rd_tap.ky) * TAP_W'(`CONV_K) + TAP_W'(rd_tap.kx);
    assign wr_ok  = w_wr && (w_wr_ky < K_SIZE) && (w_wr_kx < K_SIZE);

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[w_wr_ch][wr_idx] <= w_wr_data;
        end
    end

    // both channels for the same tap
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            weights[ch] <= mem[ch][rd_idx];
        end
    end

endmodule

// File: src/mac_array.sv
`timescale 1ns/100ps
`include "conv_consts.svh"

module mac_array (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   win_valid,
    input  conv_pkg::tap_t         win_tap,
    input  conv_pkg::pix_window_t  window,
    input  conv_pkg::tap_weights_t weights,
    output logic                   out_valid,
    output conv_pkg::out_tile_t    out_tile
);
    import conv_pkg::*;

    acc_t [`CONV_CHANNELS-1:0][`CONV_TILE_COLS-1:0] prod;
    acc_t [`CONV_CHANNELS-1:0][`CONV_TILE_COLS-1:0] acc;
    logic [`CONV_IDX_W-1:0]                         acc_base;
    logic                                           tile_done;   // acc holds a full tile

    // pixel is unsigned, so widen with a zero before the signed multiply
    always_comb begin
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int c = 0; c < `CONV_TILE_COLS; c++) begin
                prod[ch][c] = $signed({1'b0, window[c]}) * $signed(weights[ch]);
            end
        end
    end

    //////////////////////////////////////////////////
    // lock-step accumulate, reload on first tap
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                for (int c = 0; c < `CONV_TILE_COLS; c++) begin
                    if (win_tap.first) begin
                        acc[ch][c] <= prod[ch][c];
                    end else begin
                        acc[ch][c] <= acc[ch][c] + prod[ch][c];
                    end
                end
            end
            acc_base <= win_tap.tile_base;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tile_done <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            tile_done <= win_valid && win_tap.last;
            out_valid <= tile_done;
        end
    end

    // next tile may already be loading into acc
    always_ff @(posedge clk) begin
        if (tile_done) begin
            out_tile.acc       <= acc;
            out_tile.tile_base <= acc_base;
        end
    end

endmodule

// File: src/conv_front.sv
`timescale 1ns/100ps
`include "conv_consts.svh"

module conv_front (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [`CONV_IDX_W-1:0]            ix,
    input  logic                              pix_wr,
    input  logic [1:0]                        pix_wr_row,
    input  logic [`CONV_IDX_W-1:0]            pix_wr_col,
    input  conv_pkg::pixel_t                  pix_wr_data,
    input  logic                              w_wr,
    input  logic [$clog2(`CONV_CHANNELS)-1:0] w_wr_ch,
    input  logic [1:0]                        w_wr_ky,
    input  logic [1:0]                        w_wr_kx,
    input  conv_pkg::weight_t                 w_wr_data,
    output logic                              busy,
    output logic                              done,
    output logic                              out_valid,
    output conv_pkg::out_tile_t               out_tile
);
    import conv_pkg::*;

    logic         tap_valid;
    tap_t         tap;
    row_pixels_t  row_data;
    logic         win_valid;
    tap_t         win_tap;
    tap_t         mid_tap;
    pix_window_t  window;
    tap_weights_t weights;
    logic         pix_wr_en;
    logic         w_wr_en;

    // buffers are frozen during a run
    assign pix_wr_en = pix_wr && !busy;
    assign w_wr_en   = w_wr && !busy;

    //////////////////////////////////////////////////
    // cycle 0: tap issue
    //////////////////////////////////////////////////

    conv_sequencer conv_sequencer_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .ix        (ix),
        .busy      (busy),
        .done      (done),
        .tap_valid (tap_valid),
        .tap       (tap)
    );

    //////////////////////////////////////////////////
    // cycles 1 and 2: row, window and weights
    //////////////////////////////////////////////////

    line_buffer line_buffer_inst (
        .clk         (clk),
        .pix_wr      (pix_wr_en),
        .pix_wr_row  (pix_wr_row),
        .pix_wr_col  (pix_wr_col),
        .pix_wr_data (pix_wr_data),
        .rd_row      (tap.ky),
        .row_out     (row_data)
    );

    window_shifter window_shifter_inst (
        .clk       (clk),
        .reset     (reset),
        .tap_valid (tap_valid),
        .tap       (tap),
        .row_in    (row_data),
        .win_valid (win_valid),
        .win_tap   (win_tap),
        .window    (window),
        .mid_tap   (mid_tap)
    );

    weight_store weight_store_inst (
        .clk       (clk),
        .w_wr      (w_wr_en),
        .w_wr_ch   (w_wr_ch),
        .w_wr_ky   (w_wr_ky),
        .w_wr_kx   (w_wr_kx),
        .w_wr_data (w_wr_data),
        .rd_tap    (mid_tap),   // stage 1 tap
        .weights   (weights)
    );

    // cycles 3 and 4
    mac_array mac_array_inst (
        .clk       (clk),
        .reset     (reset),
        .win_valid (win_valid),
        .win_tap   (win_tap),
        .window    (window),
        .weights   (weights),
        .out_valid (out_valid),
        .out_tile  (out_tile)
    );

endmodule

// File: bench/conv_front_assert.sv
`timescale 1ns/100ps

module conv_front_assert (
    input logic clk,
    input logic reset,
    input logic start,
    input logic busy,
    input logic done,
    input logic out_valid,
    input logic tap_valid
);

    // tiles only leave the array during a run
    out_in_run: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> busy)
        else $error("out_valid outside a run");

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held longer than one cycle");

    // an idle sequencer issues no taps until a start arrives
    tap_idle: assert property (@(posedge clk) disable iff (reset)
        !busy && !start |=> !tap_valid)
        else $error("tap_valid rose while the sequencer was idle");

endmodule

bind conv_front conv_front_assert conv_front_assert_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .out_valid (out_valid),
    .tap_valid (tap_valid)
);

// File: bench/conv_front_tb.sv
`timescale 1ns/100ps
`include "conv_consts.svh"

module conv_front_tb;
    import conv_pkg::*;

    localparam int TIMEOUT = 2000;   // cycles allowed per wait

    logic                              clk;
    logic                              reset;
    logic                              start;
    logic [`CONV_IDX_W-1:0]            ix;
    logic                              pix_wr;
    logic [1:0]                        pix_wr_row;
    logic [`CONV_IDX_W-1:0]            pix_wr_col;
    pixel_t                            pix_wr_data;
    logic                              w_wr;
    logic [$clog2(`CONV_CHANNELS)-1:0] w_wr_ch;
    logic [1:0]                        w_wr_ky;
    logic [1:0]                        w_wr_kx;
    weight_t                           w_wr_data;
    logic                              busy;
    logic                              done;
    logic                              out_valid;
    out_tile_t                         out_tile;

    pixel_t      pix_model [`CONV_ROWS][`CONV_ROW_PIXELS];    // what the buffer should hold
    weight_t     w_model [`CONV_CHANNELS][`CONV_K][`CONV_K];
    logic [31:0] rand_state = 32'hd466;
    int          run_ox;
    int          tiles_expected;
    int          tiles_seen;
    bit          done_seen;
    bit          run_active = 1'b0;

    conv_front conv_front_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // sum over the nine taps, columns past the buffer read as zero
    function automatic out_tile_t conv_ref(input int base);
        out_tile_t t;
        int        sum;
        int        col;
        t = '0;
        t.tile_base = base[`CONV_IDX_W-1:0];
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int c = 0; c < `CONV_TILE_COLS; c++) begin
                sum = 0;
                for (int ky = 0; ky < `CONV_K; ky++) begin
                    for (int kx = 0; kx < `CONV_K; kx++) begin
                        col = base + c + kx;
                        if (col < `CONV_ROW_PIXELS) begin
                            sum += int'(pix_model[ky][col]) * int'(w_model[ch][ky][kx]);
                        end
                    end
                end
                t.acc[ch][c] = acc_t'(sum);
            end
        end
        return t;
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_tile(input out_tile_t got, input out_tile_t exp, input int ox);
        if (got.tile_base !== exp.tile_base) begin
            report_failure($sformatf("Fail at %0t: out_tile.tile_base got %0d expected %0d",
                                     $time, got.tile_base, exp.tile_base));
        end
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int c = 0; c < `CONV_TILE_COLS; c++) begin
                if (exp.tile_base + c < ox && got.acc[ch][c] !== exp.acc[ch][c]) begin
                    report_failure($sformatf(
                        "Fail at %0t: out_tile.acc[%0d][%0d] got %0d expected %0d",
                        $time, ch, c, got.acc[ch][c], exp.acc[ch][c]));
                end
            end
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    // outputs are sampled half a cycle after the edge
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (!run_active || tiles_seen >= tiles_expected) begin
                report_failure("an output tile arrived that the run should not produce");
            end
            check_tile(out_tile, conv_ref(tiles_seen * `CONV_TILE_COLS), run_ox);
            tiles_seen++;
        end
        if (!reset && done) begin
            check_flag("out_valid", out_valid, 1'b1);   // done lines up with the last tile
            if (tiles_seen != tiles_expected) begin
                report_failure("done arrived before all tiles of the run");
            end
            done_seen = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic load_pixels(input bit random);
        pixel_t data;
        for (int row = 0; row < `CONV_ROWS; row++) begin
            for (int col = 0; col < `CONV_ROW_PIXELS; col++) begin
                rand_state = lcg_next(rand_state);
                data = random ? rand_state[23:16] : pixel_t'(row * 16 + col + 1);
                @(posedge clk);
                pix_wr      <= 1'b1;
                pix_wr_row  <= row[1:0];
                pix_wr_col  <= col[`CONV_IDX_W-1:0];
                pix_wr_data <= data;
                pix_model[row][col] = data;
            end
        end
        @(posedge clk);
        pix_wr <= 1'b0;
    endtask

    task automatic load_weights(input bit random);
        weight_t data;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int ky = 0; ky < `CONV_K; ky++) begin
                for (int kx = 0; kx < `CONV_K; kx++) begin
                    rand_state = lcg_next(rand_state);
                    data = random ? weight_t'(rand_state[23:16])
                                  : weight_t'(ch * 9 + ky * 3 + kx - 8);
                    @(posedge clk);
                    w_wr      <= 1'b1;
                    w_wr_ch   <= ch[0];
                    w_wr_ky   <= ky[1:0];
                    w_wr_kx   <= kx[1:0];
                    w_wr_data <= data;
                    w_model[ch][ky][kx] = data;
                end
            end
        end
        @(posedge clk);
        w_wr <= 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== level) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                report_failure($sformatf("busy did not reach %b in time", level));
            end
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_seen) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                report_failure("the run never signalled done");
            end
        end
    endtask

    // disturb drives a stray start and writes while busy
    task automatic run_conv(input int width, input bit disturb);
        run_ox = width - 2;
        tiles_expected = (run_ox + `CONV_TILE_COLS - 1) / `CONV_TILE_COLS;
        tiles_seen = 0;
        done_seen = 1'b0;
        run_active = 1'b1;
        @(posedge clk);
        start <= 1'b1;
        ix    <= width[`CONV_IDX_W-1:0];
        @(posedge clk);
        start <= 1'b0;
        wait_busy(1'b1);
        if (disturb) begin
            repeat (3) @(posedge clk);
            start       <= 1'b1;
            pix_wr      <= 1'b1;
            pix_wr_row  <= 2'd2;
            pix_wr_col  <= 5'd10;   // read later by the third tile
            pix_wr_data <= ~pix_model[2][10];
            w_wr        <= 1'b1;
            w_wr_ch     <= 1'b1;
            w_wr_ky     <= 2'd1;
            w_wr_kx     <= 2'd1;
            w_wr_data   <= ~w_model[1][1][1];
            @(posedge clk);
            start  <= 1'b0;
            pix_wr <= 1'b0;
            w_wr   <= 1'b0;
        end
        wait_done();
        wait_busy(1'b0);
        run_active = 1'b0;
        repeat (8) @(posedge clk);   // no second run may follow
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
    endtask

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        ix          = '0;
        pix_wr      = 1'b0;
        pix_wr_row  = '0;
        pix_wr_col  = '0;
        pix_wr_data = '0;
        w_wr        = 1'b0;
        w_wr_ch     = '0;
        w_wr_ky     = '0;
        w_wr_kx     = '0;
        w_wr_data   = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        load_pixels(1'b0);
        load_weights(1'b0);
        run_conv(6, 1'b0);           // one tile
        load_pixels(1'b1);
        load_weights(1'b1);
        run_conv(16, 1'b0);          // four tiles
        run_conv(9, 1'b0);           // partial last tile
        load_pixels(1'b1);
        load_weights(1'b1);
        run_conv(12, 1'b0);          // fresh data, accumulators reload
        run_conv(16, 1'b1);          // start and writes while busy
        $display("All tests passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/conv_pkg.sv
src/conv_sequencer.sv
src/line_buffer.sv
src/window_shifter.sv
src/weight_store.sv
src/mac_array.sv
src/conv_front.sv
bench/conv_front_assert.sv
bench/conv_front_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the conv_front testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module conv_front_tb \
    -f src.f -o conv_front_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/conv_front_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0
